//--- Makefile
SIM      := verilator
TOP      := sys_unit_tb
FILELIST := src.f
FLAGS    := --binary --timing --assert
OBJ_DIR  := obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

//--- src.f
+incdir+src
src/csr_pkg.sv
src/sys_pkg.sv
src/sys_decode.sv
src/csr_exec.sv
src/csr_file.sv
src/trap_ctrl.sv
src/sys_unit_top.sv
verif/sys_unit_assertions.sv
verif/sys_unit_tb.sv

//--- src/csr_exec.sv
`timescale 1ns/1ps
`include "csr_macros.svh"

module csr_exec (
  input  logic                 clk,
  input  logic                 i_arst_n,
  input  logic                 i_valid,
  input  logic                 i_is_csr,
  input  csr_pkg::csr_op_e     i_op,
  input  logic                 i_is_imm,
  input  logic [4:0]           i_zimm,
  input  logic [`XLEN-1:0]     i_rs1_data,
  input  logic [4:0]           i_rd_idx,
  input  logic [`XLEN-1:0]     i_old_val,
  input  logic                 i_addr_ok,
  output logic                 o_wen,
  output logic [`XLEN-1:0]     o_wdata,
  output logic                 o_rd_wen,
  output logic [4:0]           o_rd_idx,
  output logic [`XLEN-1:0]     o_rd_data
);
  import csr_pkg::*;

  csr_data_t operand;
  logic      csr_go;

  assign operand = i_is_imm ? {{(`XLEN-5){1'b0}}, i_zimm} : i_rs1_data;
  assign csr_go  = i_valid && i_is_csr;

  always_comb begin
    case (i_op)
      CSR_OP_RS: o_wdata = i_old_val | operand;
      CSR_OP_RC: o_wdata = i_old_val & ~operand;
      default:   o_wdata = operand;
    endcase
  end

  // set or clear with a zero operand is a pure read
  assign o_wen = csr_go && ((i_op == CSR_OP_RW) || (operand != '0));

  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      o_rd_wen <= 1'b0;
    end else begin
      o_rd_wen <= csr_go && i_addr_ok && (i_rd_idx != 5'd0);
    end
  end

  // writeback payload, old csr value
  always_ff @(posedge clk) begin
    if (csr_go) begin
      o_rd_idx  <= i_rd_idx;
      o_rd_data <= i_old_val;
    end
  end

endmodule

//--- src/csr_file.sv
`timescale 1ns/1ps
`include "csr_macros.svh"

module csr_file (
  input  logic               clk,
  input  logic               i_arst_n,
  input  csr_pkg::csr_addr_e i_addr,
  input  logic               i_wen,
  input  logic [`XLEN-1:0]   i_wdata,
  input  logic               i_ecall,
  input  logic               i_mret,
  input  logic [`XLEN-1:0]   i_pc,
  output logic [`XLEN-1:0]   o_rdata,
  output logic               o_addr_ok,
  output logic [`XLEN-1:0]   o_mtvec,
  output logic [`XLEN-1:0]   o_mepc
);
  import csr_pkg::*;

  csr_data_t mstatus;
  csr_data_t mtvec;
  csr_data_t mepc;
  csr_data_t mcause;

  csr_data_t mstatus_trap;
  csr_data_t mstatus_ret;
  logic      addr_known;
  logic      read_only;
  logic      wr_commit;

  // read mux, unknown addresses read as zero
  always_comb begin
    addr_known = 1'b1;
    case (i_addr)
      CSR_MSTATUS:   o_rdata = mstatus;
      CSR_MTVEC:     o_rdata = mtvec;
      CSR_MEPC:      o_rdata = mepc;
      CSR_MCAUSE:    o_rdata = mcause;
      CSR_MVENDORID: o_rdata = `MVENDORID_VAL;
      CSR_MARCHID:   o_rdata = `MARCHID_VAL;
      default: begin
        addr_known = 1'b0;
        o_rdata    = '0;
      end
    endcase
  end

  // top two address bits set means read-only space
  assign read_only = (i_addr[`CSR_AW-1:`CSR_AW-2] == 2'b11);
  assign o_addr_ok = addr_known && !(read_only && i_wen);
  assign wr_commit = i_wen && o_addr_ok;

  // trap entry: save MIE into MPIE, mask, record machine mode
  always_comb begin
    mstatus_trap = mstatus;
    mstatus_trap[`MSTATUS_MPIE] = mstatus[`MSTATUS_MIE];
    mstatus_trap[`MSTATUS_MIE]  = 1'b0;
    mstatus_trap[`MSTATUS_MPP_MSB:`MSTATUS_MPP_LSB] = `PRIV_M;
  end

  // trap return: restore MIE, MPIE back to one, MPP to lowest
  always_comb begin
    mstatus_ret = mstatus;
    mstatus_ret[`MSTATUS_MIE]  = mstatus[`MSTATUS_MPIE];
    mstatus_ret[`MSTATUS_MPIE] = 1'b1;
    mstatus_ret[`MSTATUS_MPP_MSB:`MSTATUS_MPP_LSB] = `PRIV_U;
  end

  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      mstatus <= '0;
      mtvec   <= '0;
      mepc    <= '0;
      mcause  <= '0;
    end else begin
      if (wr_commit) begin
        case (i_addr)
          CSR_MSTATUS: mstatus <= i_wdata;
          CSR_MTVEC:   mtvec   <= i_wdata;
          CSR_MEPC:    mepc    <= i_wdata;
          CSR_MCAUSE:  mcause  <= i_wdata;
          default: begin
          end
        endcase
      end
      // at most one instruction per cycle, so these never overlap a write
      if (i_ecall) begin
        mepc    <= i_pc;
        mcause  <= `MCAUSE_ECALL_M;
        mstatus <= mstatus_trap;
      end
      if (i_mret) begin
        mstatus <= mstatus_ret;
      end
    end
  end

  assign o_mtvec = mtvec;
  assign o_mepc  = mepc;

endmodule

//--- src/csr_macros.svh
`ifndef CSR_MACROS_SVH
`define CSR_MACROS_SVH

// datapath and csr address widths
`define XLEN 32
`define CSR_AW 12

// cause code for an environment call from machine mode
`define MCAUSE_ECALL_M 32'd11

// identification values, read-only
`define MVENDORID_VAL 32'h0000_0a71
`define MARCHID_VAL 32'h0000_0019

// mstatus field positions
`define MSTATUS_MIE 3
`define MSTATUS_MPIE 7
`define MSTATUS_MPP_LSB 11
`define MSTATUS_MPP_MSB 12

// privilege encodings written into MPP
`define PRIV_M 2'b11
`define PRIV_U 2'b00

// mtvec mode bits sit below the base address
`define MTVEC_BASE_LSB 2

`endif

//--- src/csr_pkg.sv
`include "csr_macros.svh"

package csr_pkg;

  // full-width csr data word
  typedef logic [`XLEN-1:0] csr_data_t;

  // machine csr addresses known to this block.
  // the decoder casts any 12-bit field into this type, so unlisted values
  // can appear on the bus and are caught by the csr file
  typedef enum logic [`CSR_AW-1:0] {
    CSR_MSTATUS   = 12'h300,
    CSR_MTVEC     = 12'h305,
    CSR_MEPC      = 12'h341,
    CSR_MCAUSE    = 12'h342,
    CSR_MVENDORID = 12'hF11,
    CSR_MARCHID   = 12'hF12
  } csr_addr_e;

  // read-modify-write flavour, matches funct3[1:0] of the zicsr encodings
  typedef enum logic [1:0] {
    CSR_OP_RW = 2'b01,
    CSR_OP_RS = 2'b10,
    CSR_OP_RC = 2'b11
  } csr_op_e;

endpackage

//--- src/sys_decode.sv
`timescale 1ns/1ps
`include "csr_macros.svh"

module sys_decode (
  input  logic [`XLEN-1:0]    i_instr,
  output sys_pkg::sys_class_e o_class,
  output csr_pkg::csr_op_e    o_op,
  output logic                o_is_imm,
  output csr_pkg::csr_addr_e  o_csr_addr,
  output logic [4:0]          o_rd_idx,
  output logic [4:0]          o_zimm
);
  import sys_pkg::*;
  import csr_pkg::*;

  logic [6:0]  opcode;
  logic [2:0]  funct3;
  logic [4:0]  rs1_idx;
  logic [11:0] funct12;
  logic        regs_zero;

  assign opcode  = i_instr[OPC_MSB:OPC_LSB];
  assign funct3  = i_instr[F3_MSB:F3_LSB];
  assign rs1_idx = i_instr[RS1_MSB:RS1_LSB];
  assign funct12 = i_instr[CSR_MSB:CSR_LSB];

  // the csr field doubles as funct12 for ecall and mret
  assign o_csr_addr = csr_addr_e'(i_instr[CSR_MSB:CSR_LSB]);
  assign o_rd_idx   = i_instr[RD_MSB:RD_LSB];

  // rs1 field carries the immediate for the i forms
  assign o_zimm   = rs1_idx;
  assign o_is_imm = funct3[2];

  // ecall and mret require rd and rs1 both zero
  assign regs_zero = (rs1_idx == 5'd0) && (o_rd_idx == 5'd0);

  always_comb begin
    o_class = SYS_NONE;
    o_op    = CSR_OP_RW;
    if (opcode == OPC_SYSTEM) begin
      case (funct3)
        F3_PRIV: begin
          if (regs_zero && funct12 == FUNCT12_ECALL) begin
            o_class = SYS_ECALL;
          end else if (regs_zero && funct12 == FUNCT12_MRET) begin
            o_class = SYS_MRET;
          end
        end
        F3_CSRRW,
        F3_CSRRS,
        F3_CSRRC,
        F3_CSRRWI,
        F3_CSRRSI,
        F3_CSRRCI: begin
          o_class = SYS_CSR;
          o_op    = csr_op_e'(funct3[1:0]);
        end
        // funct3 4 is reserved
        default: begin
          o_class = SYS_NONE;
        end
      endcase
    end
  end

endmodule

//--- src/sys_pkg.sv
`include "csr_macros.svh"

package sys_pkg;

  // what the decoder found in the issued word
  typedef enum logic [1:0] {
    SYS_NONE  = 2'd0,
    SYS_CSR   = 2'd1,
    SYS_ECALL = 2'd2,
    SYS_MRET  = 2'd3
  } sys_class_e;

  // only the SYSTEM major opcode is handled here
  typedef enum logic [6:0] {
    OPC_SYSTEM = 7'b1110011
  } sys_opcode_e;

  typedef enum logic [2:0] {
    F3_PRIV   = 3'd0,
    F3_CSRRW  = 3'd1,
    F3_CSRRS  = 3'd2,
    F3_CSRRC  = 3'd3,
    F3_CSRRWI = 3'd5,
    F3_CSRRSI = 3'd6,
    F3_CSRRCI = 3'd7
  } sys_funct3_e;

  // instruction field positions
  localparam int OPC_LSB = 0;
  localparam int OPC_MSB = 6;
  localparam int RD_LSB  = 7;
  localparam int RD_MSB  = 11;
  localparam int F3_LSB  = 12;
  localparam int F3_MSB  = 14;
  localparam int RS1_LSB = 15;
  localparam int RS1_MSB = 19;
  localparam int CSR_LSB = 20;
  localparam int CSR_MSB = CSR_LSB + `CSR_AW - 1;

  // funct12 values of the privileged instructions under F3_PRIV
  localparam logic [11:0] FUNCT12_ECALL = 12'h000;
  localparam logic [11:0] FUNCT12_MRET  = 12'h302;

endpackage

//--- src/sys_unit_top.sv
`timescale 1ns/1ps
`include "csr_macros.svh"

module sys_unit_top (
  input  logic             clk,
  input  logic             i_arst_n,
  input  logic             i_valid,
  input  logic [`XLEN-1:0] i_instr,
  input  logic [`XLEN-1:0] i_pc,
  input  logic [`XLEN-1:0] i_rs1_data,
  output logic             o_rd_wen,
  output logic [4:0]       o_rd_idx,
  output logic [`XLEN-1:0] o_rd_data,
  output logic             o_redirect,
  output logic [`XLEN-1:0] o_redirect_pc,
  output logic             o_illegal
);
  import sys_pkg::*;
  import csr_pkg::*;

  // decode outputs
  sys_class_e dec_class;
  csr_op_e    dec_op;
  logic       dec_is_imm;
  csr_addr_e  dec_csr_addr;
  logic [4:0] dec_rd_idx;
  logic [4:0] dec_zimm;

  // csr file traffic
  logic             csr_wen;
  logic [`XLEN-1:0] csr_wdata;
  logic [`XLEN-1:0] csr_rdata;
  logic             csr_addr_ok;
  logic [`XLEN-1:0] csr_mtvec;
  logic [`XLEN-1:0] csr_mepc;
  logic             trap_ecall;
  logic             trap_mret;

  sys_decode u_decode (
    .i_instr    (i_instr),
    .o_class    (dec_class),
    .o_op       (dec_op),
    .o_is_imm   (dec_is_imm),
    .o_csr_addr (dec_csr_addr),
    .o_rd_idx   (dec_rd_idx),
    .o_zimm     (dec_zimm)
  );

  csr_exec u_exec (
    .clk        (clk),
    .i_arst_n   (i_arst_n),
    .i_valid    (i_valid),
    .i_is_csr   (dec_class == SYS_CSR),
    .i_op       (dec_op),
    .i_is_imm   (dec_is_imm),
    .i_zimm     (dec_zimm),
    .i_rs1_data (i_rs1_data),
    .i_rd_idx   (dec_rd_idx),
    .i_old_val  (csr_rdata),
    .i_addr_ok  (csr_addr_ok),
    .o_wen      (csr_wen),
    .o_wdata    (csr_wdata),
    .o_rd_wen   (o_rd_wen),
    .o_rd_idx   (o_rd_idx),
    .o_rd_data  (o_rd_data)
  );

  csr_file u_csr_file (
    .clk       (clk),
    .i_arst_n  (i_arst_n),
    .i_addr    (dec_csr_addr),
    .i_wen     (csr_wen),
    .i_wdata   (csr_wdata),
    .i_ecall   (trap_ecall),
    .i_mret    (trap_mret),
    .i_pc      (i_pc),
    .o_rdata   (csr_rdata),
    .o_addr_ok (csr_addr_ok),
    .o_mtvec   (csr_mtvec),
    .o_mepc    (csr_mepc)
  );

  trap_ctrl u_trap_ctrl (
    .clk           (clk),
    .i_arst_n      (i_arst_n),
    .i_valid       (i_valid),
    .i_class       (dec_class),
    .i_addr_ok     (csr_addr_ok),
    .i_mtvec       (csr_mtvec),
    .i_mepc        (csr_mepc),
    .o_ecall       (trap_ecall),
    .o_mret        (trap_mret),
    .o_redirect    (o_redirect),
    .o_redirect_pc (o_redirect_pc),
    .o_illegal     (o_illegal)
  );

endmodule

//--- src/trap_ctrl.sv
`timescale 1ns/1ps
`include "csr_macros.svh"

module trap_ctrl (
  input  logic                clk,
  input  logic                i_arst_n,
  input  logic                i_valid,
  input  sys_pkg::sys_class_e i_class,
  input  logic                i_addr_ok,
  input  logic [`XLEN-1:0]    i_mtvec,
  input  logic [`XLEN-1:0]    i_mepc,
  output logic                o_ecall,
  output logic                o_mret,
  output logic                o_redirect,
  output logic [`XLEN-1:0]    o_redirect_pc,
  output logic                o_illegal
);
  import sys_pkg::*;

  logic             csr_go;
  logic             trap_go;
  logic [`XLEN-1:0] trap_vec;

  // strobes into the csr file, same cycle as i_valid
  assign o_ecall = i_valid && (i_class == SYS_ECALL);
  assign o_mret  = i_valid && (i_class == SYS_MRET);
  assign csr_go  = i_valid && (i_class == SYS_CSR);
  assign trap_go = o_ecall || o_mret;

  // direct mode only, mode bits dropped
  assign trap_vec = {i_mtvec[`XLEN-1:`MTVEC_BASE_LSB], {`MTVEC_BASE_LSB{1'b0}}};

  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      o_redirect <= 1'b0;
      o_illegal  <= 1'b0;
    end else begin
      o_redirect <= trap_go;
      o_illegal  <= csr_go && !i_addr_ok;
    end
  end

  // mepc is sampled before the mret edge takes effect
  always_ff @(posedge clk) begin
    if (trap_go) begin
      o_redirect_pc <= o_ecall ? trap_vec : i_mepc;
    end
  end

endmodule

//--- verif/sys_unit_assertions.sv
`timescale 1ns/1ps

module sys_unit_assertions (
  input logic                clk,
  input logic                i_arst_n,
  input logic                i_valid,
  input sys_pkg::sys_class_e i_class,
  input logic                o_rd_wen,
  input logic [4:0]          o_rd_idx,
  input logic                o_redirect,
  input logic                o_illegal
);
  import sys_pkg::*;

  logic trap_issued;

  assign trap_issued = i_valid && ((i_class == SYS_ECALL) || (i_class == SYS_MRET));

  // one instruction gives one kind of result
  a_single_pulse: assert property (@(posedge clk) disable iff (!i_arst_n)
    $onehot0({o_rd_wen, o_redirect, o_illegal}))
    else $error("more than one result pulse high in the same cycle");

  // x0 is never written back
  a_rd_idx_nonzero: assert property (@(posedge clk) disable iff (!i_arst_n)
    o_rd_wen |-> (o_rd_idx != 5'd0))
    else $error("writeback pulse with rd index zero");

  a_redirect_follows: assert property (@(posedge clk) disable iff (!i_arst_n)
    trap_issued |=> o_redirect)
    else $error("no redirect one cycle after ecall or mret");

endmodule

bind sys_unit_top sys_unit_assertions u_assertions (
  .clk        (clk),
  .i_arst_n   (i_arst_n),
  .i_valid    (i_valid),
  .i_class    (dec_class),
  .o_rd_wen   (o_rd_wen),
  .o_rd_idx   (o_rd_idx),
  .o_redirect (o_redirect),
  .o_illegal  (o_illegal)
);

//--- verif/sys_unit_tb.sv
`timescale 1ns/1ps
`include "csr_macros.svh"

module sys_unit_tb;
  import sys_pkg::*;
  import csr_pkg::*;

  localparam time DRIVE_DLY = 2ns;
  localparam int  RESULT_TIMEOUT = 10;

  logic             clk;
  logic             i_arst_n;
  logic             i_valid;
  logic [`XLEN-1:0] i_instr;
  logic [`XLEN-1:0] i_pc;
  logic [`XLEN-1:0] i_rs1_data;
  logic             o_rd_wen;
  logic [4:0]       o_rd_idx;
  logic [`XLEN-1:0] o_rd_data;
  logic             o_redirect;
  logic [`XLEN-1:0] o_redirect_pc;
  logic             o_illegal;

  // reference copy of the writable csrs
  csr_data_t   m_mstatus;
  csr_data_t   m_mtvec;
  csr_data_t   m_mepc;
  csr_data_t   m_mcause;

  sys_unit_top u_dut (
    .clk           (clk),
    .i_arst_n      (i_arst_n),
    .i_valid       (i_valid),
    .i_instr       (i_instr),
    .i_pc          (i_pc),
    .i_rs1_data    (i_rs1_data),
    .o_rd_wen      (o_rd_wen),
    .o_rd_idx      (o_rd_idx),
    .o_rd_data     (o_rd_data),
    .o_redirect    (o_redirect),
    .o_redirect_pc (o_redirect_pc),
    .o_illegal     (o_illegal)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("TEST FAIL");
    $fatal(1, "simulation stopped on first error");
  endtask

  task automatic check_data(input string name, input csr_data_t got, input csr_data_t exp);
    if (got !== exp) begin
      fail_run($sformatf("mismatch at %0t: %s got 0x%08h expected 0x%08h", $time, name, got, exp));
    end
  endtask

  task automatic check_idx(input string name, input logic [4:0] got, input logic [4:0] exp);
    if (got !== exp) begin
      fail_run($sformatf("mismatch at %0t: %s got %0d expected %0d", $time, name, got, exp));
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      fail_run($sformatf("mismatch at %0t: %s got %b expected %b", $time, name, got, exp));
    end
  endtask

  function automatic logic [`XLEN-1:0] enc_csr(input csr_op_e op, input logic imm,
                                               input logic [`CSR_AW-1:0] addr,
                                               input logic [4:0] src, input logic [4:0] rd);
    logic [`XLEN-1:0] w;
    w = '0;
    w[OPC_MSB:OPC_LSB] = OPC_SYSTEM;
    w[RD_MSB:RD_LSB]   = rd;
    w[F3_MSB:F3_LSB]   = {imm, op};
    w[RS1_MSB:RS1_LSB] = src;
    w[CSR_MSB:CSR_LSB] = addr;
    return w;
  endfunction

  // ecall and mret differ only in funct12
  function automatic logic [`XLEN-1:0] enc_priv(input logic [11:0] funct12);
    logic [`XLEN-1:0] w;
    w = '0;
    w[OPC_MSB:OPC_LSB] = OPC_SYSTEM;
    w[CSR_MSB:CSR_LSB] = funct12;
    return w;
  endfunction

  function automatic logic [4:0] rand_rd();
    return 5'($urandom_range(31, 1));
  endfunction

  function automatic csr_data_t model_read(input logic [`CSR_AW-1:0] addr);
    case (addr)
      CSR_MSTATUS:   return m_mstatus;
      CSR_MTVEC:     return m_mtvec;
      CSR_MEPC:      return m_mepc;
      CSR_MCAUSE:    return m_mcause;
      CSR_MVENDORID: return `MVENDORID_VAL;
      CSR_MARCHID:   return `MARCHID_VAL;
      default:       return '0;
    endcase
  endfunction

  function automatic logic model_known(input logic [`CSR_AW-1:0] addr);
    return (addr == CSR_MSTATUS) || (addr == CSR_MTVEC) || (addr == CSR_MEPC) ||
           (addr == CSR_MCAUSE) || (addr == CSR_MVENDORID) || (addr == CSR_MARCHID);
  endfunction

  task automatic drive_instr(input logic [`XLEN-1:0] instr, input csr_data_t pc,
                             input csr_data_t rs1);
    @(posedge clk);
    #DRIVE_DLY;
    i_valid    = 1'b1;
    i_instr    = instr;
    i_pc       = pc;
    i_rs1_data = rs1;
  endtask

  task automatic drive_idle();
    @(posedge clk);
    #DRIVE_DLY;
    i_valid    = 1'b0;
    i_instr    = '0;
    i_pc       = '0;
    i_rs1_data = '0;
  endtask

  // every issued instruction in these tests yields exactly one pulse
  task automatic wait_result();
    int cycles;
    cycles = 0;
    while (!(o_rd_wen || o_redirect || o_illegal)) begin
      if (cycles == RESULT_TIMEOUT) begin
        fail_run("timeout: the DUT gave no result pulse");
      end
      @(posedge clk);
      #DRIVE_DLY;
      cycles++;
    end
    if (cycles != 0) begin
      fail_run("result pulse came later than one cycle after the strobe");
    end
  endtask

  task automatic csr_issue(input csr_op_e op, input logic imm, input logic [`CSR_AW-1:0] addr,
                           input logic [4:0] src, input csr_data_t rs1, input logic [4:0] rd,
                           output logic exp_ok, output csr_data_t exp_old);
    csr_data_t operand;
    csr_data_t new_val;
    logic      writes;
    operand = imm ? {{(`XLEN-5){1'b0}}, src} : rs1;
    exp_old = model_read(addr);
    writes  = (op == CSR_OP_RW) || (operand != '0);
    case (op)
      CSR_OP_RS: new_val = exp_old | operand;
      CSR_OP_RC: new_val = exp_old & ~operand;
      default:   new_val = operand;
    endcase
    // 0xF.. space is read-only
    exp_ok = model_known(addr) && !((addr[11:8] == 4'hF) && writes);
    if (exp_ok && writes) begin
      case (addr)
        CSR_MSTATUS: m_mstatus = new_val;
        CSR_MTVEC:   m_mtvec   = new_val;
        CSR_MEPC:    m_mepc    = new_val;
        CSR_MCAUSE:  m_mcause  = new_val;
        default: begin
        end
      endcase
    end
    drive_instr(enc_csr(op, imm, addr, src, rd), '0, rs1);
  endtask

  task automatic csr_check(input logic exp_ok, input csr_data_t exp_old, input logic [4:0] rd);
    wait_result();
    check_flag("o_redirect", o_redirect, 1'b0);
    check_flag("o_illegal", o_illegal, !exp_ok);
    check_flag("o_rd_wen", o_rd_wen, exp_ok);
    if (exp_ok) begin
      check_idx("o_rd_idx", o_rd_idx, rd);
      check_data("o_rd_data", o_rd_data, exp_old);
    end
  endtask

  task automatic csr_access(input csr_op_e op, input logic imm, input logic [`CSR_AW-1:0] addr,
                            input logic [4:0] src, input csr_data_t rs1);
    logic      ok;
    csr_data_t old;
    logic [4:0] rd;
    rd = rand_rd();
    csr_issue(op, imm, addr, src, rs1, rd, ok, old);
    drive_idle();
    csr_check(ok, old, rd);
  endtask

  task automatic csr_read(input logic [`CSR_AW-1:0] addr);
    csr_access(CSR_OP_RS, 1'b0, addr, 5'd0, '0);
  endtask

  task automatic trap_access(input logic is_mret, input csr_data_t pc);
    csr_data_t exp_pc;
    if (is_mret) begin
      exp_pc = m_mepc;
      m_mstatus[`MSTATUS_MIE]  = m_mstatus[`MSTATUS_MPIE];
      m_mstatus[`MSTATUS_MPIE] = 1'b1;
      m_mstatus[`MSTATUS_MPP_MSB:`MSTATUS_MPP_LSB] = 2'b00;
    end else begin
      exp_pc   = {m_mtvec[`XLEN-1:2], 2'b00};
      m_mepc   = pc;
      m_mcause = 32'd11;
      m_mstatus[`MSTATUS_MPIE] = m_mstatus[`MSTATUS_MIE];
      m_mstatus[`MSTATUS_MIE]  = 1'b0;
      m_mstatus[`MSTATUS_MPP_MSB:`MSTATUS_MPP_LSB] = 2'b11;
    end
    drive_instr(enc_priv(is_mret ? FUNCT12_MRET : FUNCT12_ECALL), pc, '0);
    drive_idle();
    wait_result();
    check_flag("o_redirect", o_redirect, 1'b1);
    check_flag("o_rd_wen", o_rd_wen, 1'b0);
    check_flag("o_illegal", o_illegal, 1'b0);
    check_data("o_redirect_pc", o_redirect_pc, exp_pc);
  endtask

  task automatic test_reset_values();
    csr_read(CSR_MSTATUS);
    csr_read(CSR_MTVEC);
    csr_read(CSR_MEPC);
    csr_read(CSR_MCAUSE);
    csr_read(CSR_MVENDORID);
    csr_read(CSR_MARCHID);
  endtask

  task automatic test_csr_rw_set_clear();
    csr_addr_e addrs[4] = '{CSR_MSTATUS, CSR_MTVEC, CSR_MEPC, CSR_MCAUSE};
    csr_op_e   ops[3]   = '{CSR_OP_RW, CSR_OP_RS, CSR_OP_RC};
    foreach (addrs[a]) begin
      foreach (ops[o]) begin
        csr_access(ops[o], 1'b0, addrs[a], 5'($urandom_range(31, 1)), $urandom());
        csr_read(addrs[a]);
        csr_access(ops[o], 1'b1, addrs[a], 5'($urandom_range(31, 1)), $urandom());
        csr_read(addrs[a]);
      end
    end
  endtask

  task automatic test_ecall_trap();
    csr_access(CSR_OP_RW, 1'b0, CSR_MTVEC, 5'd1, ($urandom() & 32'hFFFF_FFFC) | 32'd1);
    csr_access(CSR_OP_RW, 1'b1, CSR_MSTATUS, 5'd0, '0);
    // zimm 8 sets MIE
    csr_access(CSR_OP_RS, 1'b1, CSR_MSTATUS, 5'd8, '0);
    trap_access(1'b0, $urandom() & 32'hFFFF_FFFC);
    csr_read(CSR_MEPC);
    csr_read(CSR_MCAUSE);
    csr_read(CSR_MSTATUS);
  endtask

  task automatic test_mret_return();
    csr_access(CSR_OP_RW, 1'b0, CSR_MEPC, 5'd1, $urandom() & 32'hFFFF_FFFC);
    trap_access(1'b1, $urandom() & 32'hFFFF_FFFC);
    csr_read(CSR_MSTATUS);
    csr_read(CSR_MEPC);
    // with MPIE cleared, mret must drop MIE and raise MPIE again
    csr_access(CSR_OP_RC, 1'b0, CSR_MSTATUS, 5'd1, 32'h0000_0080);
    trap_access(1'b1, $urandom() & 32'hFFFF_FFFC);
    csr_read(CSR_MSTATUS);
  endtask

  task automatic test_illegal_access();
    csr_access(CSR_OP_RW, 1'b0, 12'h7C0, 5'd3, $urandom());
    csr_access(CSR_OP_RW, 1'b0, CSR_MVENDORID, 5'd3, $urandom());
    csr_read(CSR_MVENDORID);
    csr_read(CSR_MSTATUS);
    csr_read(CSR_MTVEC);
    csr_read(CSR_MEPC);
    csr_read(CSR_MCAUSE);
  endtask

  // each check runs while the next strobe is already on the inputs
  task automatic test_back_to_back();
    logic       ok_a;
    logic       ok_b;
    logic       ok_c;
    csr_data_t  old_a;
    csr_data_t  old_b;
    csr_data_t  old_c;
    logic [4:0] rd_a;
    logic [4:0] rd_b;
    logic [4:0] rd_c;
    rd_a = rand_rd();
    rd_b = rand_rd();
    rd_c = rand_rd();
    csr_issue(CSR_OP_RW, 1'b0, CSR_MTVEC, 5'd2, $urandom(), rd_a, ok_a, old_a);
    csr_issue(CSR_OP_RS, 1'b0, CSR_MTVEC, 5'd0, '0, rd_b, ok_b, old_b);
    csr_check(ok_a, old_a, rd_a);
    csr_issue(CSR_OP_RC, 1'b1, CSR_MEPC, 5'($urandom_range(31, 1)), '0, rd_c, ok_c, old_c);
    csr_check(ok_b, old_b, rd_b);
    drive_idle();
    csr_check(ok_c, old_c, rd_c);
    csr_read(CSR_MEPC);
  endtask

  initial begin
    void'($urandom(32'hcc7d));
    i_arst_n   = 1'b0;
    i_valid    = 1'b0;
    i_instr    = '0;
    i_pc       = '0;
    i_rs1_data = '0;
    m_mstatus  = '0;
    m_mtvec    = '0;
    m_mepc     = '0;
    m_mcause   = '0;
    repeat (8) @(posedge clk);
    #DRIVE_DLY;
    i_arst_n = 1'b1;
    check_flag("o_rd_wen", o_rd_wen, 1'b0);
    check_flag("o_redirect", o_redirect, 1'b0);
    check_flag("o_illegal", o_illegal, 1'b0);
    test_reset_values();
    test_csr_rw_set_clear();
    test_ecall_trap();
    test_mret_return();
    test_illegal_access();
    test_back_to_back();
    drive_idle();
    $display("TEST PASS");
    $finish;
  end

endmodule
